// File: files.f
+incdir+bench
source/mipsPkg.sv
source/controller.sv
source/regFile.sv
source/alu.sv
source/nextPc.sv
source/cpuCore.sv
source/memArbiter.sv
source/unifiedMem.sv
source/cpuTop.sv
bench/cpuTb.sv

// File: Bender.yml
package:
  name: mips_subset

sources:
  - files:
      - source/mipsPkg.sv
      - source/controller.sv
      - source/regFile.sv
      - source/alu.sv
      - source/nextPc.sv
      - source/cpuCore.sv
      - source/memArbiter.sv
      - source/unifiedMem.sv
      - source/cpuTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpuTb.sv

// File: bench/cpuTasks.svh
function automatic logic [31:0] rInstr(funct_e fn, int rs, int rt, int rd, int sh);
    return {opRType, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
endfunction

function automatic logic [31:0] iInstr(opcode_e op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

function automatic logic [31:0] jInstr(opcode_e op, int target);
    return {op, target[27:2]}; // target as byte address
endfunction

function automatic logic [31:0] fillWord(int byteAddr);
    return {16'hC0DE, 6'b0, byteAddr[11:2]};
endfunction

function automatic logic [31:0] sext8(logic [7:0] b);
    return {{24{b[7]}}, b};
endfunction

function automatic int emitLoop(); // j to itself at the next free slot
    int addr;
    addr = prog.size() * 4;
    prog.push_back(jInstr(opJ, addr));
    return addr;
endfunction

task automatic startTest(string name);
    curTest  = name;
    testErrs = errCount;
endtask

task automatic endTest();
    testCount++;
    if (errCount == testErrs) begin
        $display("%-12s ok", curTest);
    end else begin
        $display("%-12s failed with %0d errors", curTest, errCount - testErrs);
    end
endtask

task automatic checkWord(string what, logic [DataWidth-1:0] exp, logic [DataWidth-1:0] act);
    checkCount++;
    if (act !== exp) begin
        $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", curTest, what, exp, act);
        errCount++;
    end
endtask

task automatic checkPc(string what, logic [DataWidth-1:0] exp, logic [DataWidth-1:0] act);
    checkCount++;
    if (act !== exp) begin
        $display("[FAIL] %s %s: expected pc 0x%08h, actual 0x%08h", curTest, what, exp, act);
        errCount++;
    end
endtask

task automatic checkFlag(string what, logic exp, logic act);
    checkCount++;
    if (act !== exp) begin
        $display("[FAIL] %s %s: expected %b, actual %b", curTest, what, exp, act);
        errCount++;
    end
endtask

// debug tasks start and end 1 ns after a rising edge
task automatic writeWord(int byteAddr, logic [DataWidth-1:0] data);
    dbgReq       = '0;
    dbgReq.req   = 1'b1;
    dbgReq.we    = 1'b1;
    dbgReq.addr  = byteAddr[MemAddrWidth+1:2];
    dbgReq.wdata = data;
    dbgReq.be    = 4'hF;
    shadow[byteAddr / 4] = data;
    @(posedge clk);
    #1;
    dbgReq = '0;
endtask

task automatic readWord(int byteAddr, output logic [DataWidth-1:0] data);
    dbgReq      = '0;
    dbgReq.req  = 1'b1;
    dbgReq.addr = byteAddr[MemAddrWidth+1:2];
    @(negedge clk);
    if (dbgGnt !== 1'b1) begin
        $display("%s: debug read of 0x%0h was not granted", curTest, byteAddr);
        errCount++;
    end
    data = dbgRdata;
    @(posedge clk);
    #1;
    dbgReq = '0;
endtask

task automatic expectWord(string what, int byteAddr, logic [DataWidth-1:0] exp);
    logic [DataWidth-1:0] got;
    readWord(byteAddr, got);
    checkWord(what, exp, got);
    shadow[byteAddr / 4] = exp; // what the core should have left there
endtask

task automatic fillRegion(int byteBase, int words);
    for (int i = 0; i < words; i++) begin
        writeWord(byteBase + 4 * i, fillWord(byteBase + 4 * i));
    end
endtask

task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) begin
        writeWord(4 * i, prog[i]);
    end
endtask

task automatic runProgram(int loopAddr);
    resetCore();
    run = 1'b1;
    while (pc !== loopAddr) begin
        @(posedge clk);
        #1;
    end
    run = 1'b0;
endtask

task automatic buildArith(int base);
    prog.delete();
    prog.push_back(iInstr(opLui, 0, 1, int'(opA[31:16])));
    prog.push_back(iInstr(opOri, 1, 1, int'(opA[15:0])));
    prog.push_back(iInstr(opLui, 0, 2, int'(opB[31:16])));
    prog.push_back(iInstr(opOri, 2, 2, int'(opB[15:0])));
    prog.push_back(rInstr(fnAddu, 1, 2, 3, 0));
    prog.push_back(iInstr(opSw, 0, 3, base));
    prog.push_back(rInstr(fnSubu, 1, 2, 4, 0));
    prog.push_back(iInstr(opSw, 0, 4, base + 4));
    prog.push_back(rInstr(fnSll, 0, 2, 5, shamt));
    prog.push_back(iInstr(opSw, 0, 5, base + 8));
    prog.push_back(rInstr(fnSlt, 1, 2, 6, 0));
    prog.push_back(iInstr(opSw, 0, 6, base + 12));
    prog.push_back(rInstr(fnSlt, 2, 1, 7, 0));
    prog.push_back(iInstr(opSw, 0, 7, base + 16));
    prog.push_back(iInstr(opSw, 0, 1, base + 20));
endtask

task automatic checkArith(int base);
    expectWord("addu", base, opA + opB);
    expectWord("subu", base + 4, opA - opB);
    expectWord("sll", base + 8, opB << shamt);
    expectWord("slt a<b", base + 12, ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
    expectWord("slt b<a", base + 16, ($signed(opB) < $signed(opA)) ? 32'd1 : 32'd0);
    expectWord("lui/ori", base + 20, opA);
endtask

task automatic resetAndGrant();
    startTest("reset");
    checkPc("after reset", 32'd0, pc);
    dbgReq.req = 1'b1; // read of word 0
    @(negedge clk);
    checkFlag("dbgGnt with request", 1'b1, dbgGnt);
    @(posedge clk);
    #1;
    dbgReq = '0;
    @(negedge clk);
    checkFlag("dbgGnt without request", 1'b0, dbgGnt);
    @(posedge clk);
    #1;
    endTest();
endtask

task automatic arithmeticOps();
    int loopAddr;
    startTest("arith");
    opA   = $urandom;
    opB   = $urandom;
    shamt = $urandom % 32;
    buildArith(ArithBase);
    loopAddr = emitLoop();
    fillRegion(ArithBase, 6);
    loadProgram();
    runProgram(loopAddr);
    checkArith(ArithBase);
    endTest();
endtask

task automatic memoryTypes();
    int loopAddr;
    logic [DataWidth-1:0] w0;
    logic [DataWidth-1:0] w1;
    logic [DataWidth-1:0] w2;
    startTest("memtypes");
    w0 = ($urandom | 32'h0000_8000) & 32'hFF7F_FFFF; // byte 1 negative, byte 2 positive
    w1 = $urandom;
    w2 = $urandom;
    prog.delete();
    prog.push_back(iInstr(opLw, 0, 1, MemBase));
    prog.push_back(iInstr(opSw, 0, 1, MemBase + 'h10));
    prog.push_back(iInstr(opLb, 0, 2, MemBase + 1));
    prog.push_back(iInstr(opSw, 0, 2, MemBase + 'h14));
    prog.push_back(iInstr(opLb, 0, 3, MemBase + 2));
    prog.push_back(iInstr(opSw, 0, 3, MemBase + 'h18));
    prog.push_back(iInstr(opSh, 0, 1, MemBase + 'h20)); // low half
    prog.push_back(iInstr(opSh, 0, 1, MemBase + 'h26)); // high half
    loopAddr = emitLoop();
    writeWord(MemBase, w0);
    writeWord(MemBase + 'h20, w1);
    writeWord(MemBase + 'h24, w2);
    fillRegion(MemBase + 'h10, 3);
    loadProgram();
    runProgram(loopAddr);
    expectWord("lw", MemBase + 'h10, w0);
    expectWord("lb negative byte", MemBase + 'h14, sext8(w0[15:8]));
    expectWord("lb positive byte", MemBase + 'h18, sext8(w0[23:16]));
    expectWord("sh low half", MemBase + 'h20, {w1[31:16], w0[15:0]});
    expectWord("sh high half", MemBase + 'h24, {w0[15:0], w2[15:0]});
    endTest();
endtask

task automatic controlFlow();
    int loopAddr;
    bit reached [8] = '{0, 1, 1, 0, 1, 1, 0, 1}; // marker stores that must run
    startTest("flow");
    prog.delete();
    prog.push_back(iInstr(opOri, 0, 1, 5));
    prog.push_back(iInstr(opOri, 0, 2, 5));
    prog.push_back(iInstr(opOri, 0, 3, 7));
    prog.push_back(iInstr(opLui, 0, 4, 'h8000));   // negative
    prog.push_back(iInstr(opOri, 0, 5, 'hABCD));   // marker value
    prog.push_back(iInstr(opBeq, 1, 2, 1));        // taken
    prog.push_back(iInstr(opSw, 0, 5, FlowBase));
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 4));
    prog.push_back(iInstr(opBeq, 1, 3, 1));        // not taken
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 8));
    prog.push_back(iInstr(opBgtz, 1, 0, 1));       // positive
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 12));
    prog.push_back(iInstr(opBgtz, 0, 0, 1));       // zero
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 16));
    prog.push_back(iInstr(opBgtz, 4, 0, 1));       // negative
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 20));
    prog.push_back(jInstr(opJ, 18 * 4));
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 24));
    prog.push_back(iInstr(opSw, 0, 5, FlowBase + 28));
    loopAddr = emitLoop();
    fillRegion(FlowBase, 8);
    loadProgram();
    runProgram(loopAddr);
    for (int i = 0; i < 8; i++) begin
        expectWord($sformatf("marker %0d", i), FlowBase + 4 * i,
                   reached[i] ? 32'h0000_ABCD : fillWord(FlowBase + 4 * i));
    end
    endTest();
endtask

task automatic callAndReturn();
    int loopAddr;
    int jalAddr;
    startTest("jal/jr");
    prog.delete();
    prog.push_back(iInstr(opOri, 0, 6, 'h77));
    jalAddr = prog.size() * 4;
    prog.push_back(jInstr(opJal, 16));
    prog.push_back(iInstr(opSw, 0, 6, JalBase + 4)); // return lands here
    loopAddr = emitLoop();
    prog.push_back(iInstr(opSw, 0, 31, JalBase)); // subroutine at byte 16
    prog.push_back(rInstr(fnJr, 31, 0, 0, 0));
    fillRegion(JalBase, 2);
    loadProgram();
    runProgram(loopAddr);
    expectWord("link register", JalBase, 32'(jalAddr + 4));
    expectWord("after return", JalBase + 4, 32'h0000_0077);
    endTest();
endtask

task automatic debugContention();
    int loopAddr;
    int n;
    int k;
    int addr;
    logic [DataWidth-1:0] got;
    startTest("contention");
    buildArith(ContBase);
    loopAddr = emitLoop();
    fillRegion(ContBase, 6);
    loadProgram();
    resetCore();
    n   = 0;
    k   = 0;
    run = 1'b1;
    while (pc !== loopAddr) begin
        if (n % 3 == 0) begin // steal every third cycle
            addr = (k % 2 == 0) ? ArithBase + 4 * ((k / 2) % 6) : 4 * ((k / 2) % 16);
            readWord(addr, got);
            checkWord($sformatf("debug read 0x%0h", addr), shadow[addr / 4], got);
            k++;
        end else begin
            @(posedge clk);
            #1;
        end
        n++;
    end
    run = 1'b0;
    checkArith(ContBase);
    endTest();
endtask

// File: bench/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;
    import mipsPkg::*;

    localparam int ArithBase = 'h800; // byte addresses of result areas
    localparam int MemBase   = 'h840;
    localparam int FlowBase  = 'h880;
    localparam int JalBase   = 'h8C0;
    localparam int ContBase  = 'h900;

    // arith, memory, flow, jal and contention programs including their loops
    localparam int ProgWords     = 16 + 9 + 20 + 6 + 16;
    localparam int RunCycles     = 2 * ProgWords + 16; // loads and stores take two, test 6 loses a third
    localparam int LoadCycles    = ProgWords + 32 + 24; // program words, fills, preloads, resets
    localparam int ReadCycles    = 36;
    localparam int TimeoutCycles = RunCycles + LoadCycles + ReadCycles + 200;

    logic                 clk;
    logic                 arstN;
    logic                 run;
    memReq_t              dbgReq;
    logic                 dbgGnt;
    logic [DataWidth-1:0] dbgRdata;
    logic [DataWidth-1:0] pc;

    logic [31:0]          prog [$];
    logic [DataWidth-1:0] shadow [int]; // last word written per word address
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    int                   shamt;
    string                curTest;
    int                   testErrs;
    int                   errCount   = 0;
    int                   checkCount = 0;
    int                   testCount  = 0;
    int                   cycleCount = 0;

    cpuTop i_dut (
        .clk(clk), .arstN(arstN), .run(run),
        .dbgReq(dbgReq), .dbgGnt(dbgGnt), .dbgRdata(dbgRdata),
        .pc(pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout after %0d cycles, the program never reached its loop",
                     TimeoutCycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // pc and state only, registers and memory keep their contents
    task automatic resetCore();
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
    endtask

    `include "cpuTasks.svh"

    initial begin
        void'($urandom(24000));
        arstN  = 1'b0;
        run    = 1'b0;
        dbgReq = '0;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;

        resetAndGrant();
        arithmeticOps();
        memoryTypes();
        controlFlow();
        callAndReturn();
        debugContention();

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: source/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          run,
    input  mipsPkg::memReq_t              dbgReq,
    output logic                          dbgGnt,
    output logic [mipsPkg::DataWidth-1:0] dbgRdata,
    output logic [mipsPkg::DataWidth-1:0] pc
);
    import mipsPkg::*;

    memReq_t              fetchReq, dataReq, memReq;
    logic                 fetchGnt, dataGnt;
    logic [DataWidth-1:0] memRdata;

    assign dbgRdata = memRdata;

    cpuCore i_core (
        .clk(clk), .arstN(arstN), .run(run),
        .fetchReq(fetchReq), .dataReq(dataReq),
        .fetchGnt(fetchGnt), .dataGnt(dataGnt),
        .rdata(memRdata), .pc(pc)
    );

    memArbiter i_arb (
        .dbgReq(dbgReq), .dataReq(dataReq), .fetchReq(fetchReq),
        .dbgGnt(dbgGnt), .dataGnt(dataGnt), .fetchGnt(fetchGnt),
        .memReq(memReq)
    );

    unifiedMem i_mem (.clk(clk), .req(memReq), .rdata(memRdata));

endmodule

// File: source/unifiedMem.sv
`timescale 1ns/1ns

module unifiedMem (
    input  logic                          clk,
    input  mipsPkg::memReq_t              req,
    output logic [mipsPkg::DataWidth-1:0] rdata
);
    import mipsPkg::*;

    logic [DataWidth-1:0] mem [2**MemAddrWidth];

    assign rdata = mem[req.addr]; // async read, shared by all requesters

    always_ff @(posedge clk) begin
        if (req.req && req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i]) begin
                    mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: source/memArbiter.sv
`timescale 1ns/1ns

module memArbiter (
    input  mipsPkg::memReq_t dbgReq,
    input  mipsPkg::memReq_t dataReq,
    input  mipsPkg::memReq_t fetchReq,
    output logic             dbgGnt,
    output logic             dataGnt,
    output logic             fetchGnt,
    output mipsPkg::memReq_t memReq
);
    import mipsPkg::*;

    // fixed priority debug > data > fetch
    always_comb begin
        dbgGnt   = 1'b0;
        dataGnt  = 1'b0;
        fetchGnt = 1'b0;
        memReq   = '0;
        if (dbgReq.req) begin
            dbgGnt = 1'b1;
            memReq = dbgReq;
        end else if (dataReq.req) begin
            dataGnt = 1'b1;
            memReq  = dataReq;
        end else if (fetchReq.req) begin
            fetchGnt = 1'b1;
            memReq   = fetchReq;
        end
    end

    gntOneHot: assert final ($onehot0({dbgGnt, dataGnt, fetchGnt}));

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ns

module cpuCore (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          run,
    output mipsPkg::memReq_t              fetchReq,
    output mipsPkg::memReq_t              dataReq,
    input  logic                          fetchGnt,
    input  logic                          dataGnt,
    input  logic [mipsPkg::DataWidth-1:0] rdata,
    output logic [mipsPkg::DataWidth-1:0] pc
);
    import mipsPkg::*;

    coreState_e state;
    logic [DataWidth-1:0]    instrHold;
    logic [DataWidth-1:0]    instr;
    ctrl_t                   ctrl;
    logic                    memAccess;
    logic                    advance;
    logic [DataWidth-1:0]    pcPlus4;
    logic [DataWidth-1:0]    rdataA, rdataB;
    logic [DataWidth-1:0]    extImm, aluA, aluB, aluResult;
    logic [RegAddrWidth-1:0] waddr;
    logic [DataWidth-1:0]    wdata, loadData;
    logic [DataWidth-1:0]    storeData;
    logic [3:0]              storeBe;
    logic [1:0]              byteOff;

    // fetched word is live during issue, held while the data access waits
    assign instr     = (state == stIssue) ? rdata : instrHold;
    assign memAccess = ctrl.dmWe || (ctrl.wdSel == wdMem);
    assign advance   = (state == stIssue && fetchGnt && !memAccess) ||
                       (state == stMem && dataGnt);

    controller i_ctrl (.instr(instr), .ctrl(ctrl));

    assign waddr = (ctrl.wrSel == wrRd) ? instr[15:11] :
                   (ctrl.wrSel == wrRa) ? 5'd31 : instr[20:16];

    regFile i_rf (
        .clk(clk), .arstN(arstN),
        .raddrA(instr[25:21]), .raddrB(instr[20:16]),
        .waddr(waddr), .we(ctrl.rfWe && advance), .wdata(wdata),
        .rdataA(rdataA), .rdataB(rdataB)
    );

    assign extImm = (ctrl.extOp == extSign) ? {{16{instr[15]}}, instr[15:0]} :
                                              {16'b0, instr[15:0]};
    assign aluA   = ctrl.aSel ? {27'b0, instr[10:6]} : rdataA;
    assign aluB   = ctrl.bSel ? extImm : rdataB;

    alu i_alu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult));

    nextPc i_npc (
        .clk(clk), .arstN(arstN), .advance(advance), .op(ctrl.npcOp),
        .imm16(instr[15:0]), .jIndex(instr[25:0]),
        .regTarget(rdataA), .cmpA(rdataA), .cmpB(rdataB),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    assign byteOff = aluResult[1:0];

    always_comb begin
        case (ctrl.dmType)
            memHalf: begin
                storeBe   = aluResult[1] ? 4'b1100 : 4'b0011;
                storeData = {2{rdataB[15:0]}}; // be picks the lane
                loadData  = aluResult[1] ? {{16{rdata[31]}}, rdata[31:16]} :
                                           {{16{rdata[15]}}, rdata[15:0]};
            end
            memByte: begin
                storeBe   = 4'b0001 << byteOff;
                storeData = {4{rdataB[7:0]}};
                loadData  = {{24{rdata[8*byteOff+7]}}, rdata[8*byteOff +: 8]};
            end
            default: begin
                storeBe   = 4'b1111;
                storeData = rdataB;
                loadData  = rdata;
            end
        endcase
    end

    assign wdata = (ctrl.wdSel == wdMem)    ? loadData :
                   (ctrl.wdSel == wdPcLink) ? pcPlus4 : aluResult;

    always_comb begin
        fetchReq       = '0;
        fetchReq.req   = run && (state == stIssue);
        fetchReq.addr  = pc[MemAddrWidth+1:2];
        dataReq        = '0;
        dataReq.req    = run && (state == stMem);
        dataReq.we     = ctrl.dmWe;
        dataReq.addr   = aluResult[MemAddrWidth+1:2];
        dataReq.wdata  = storeData;
        dataReq.be     = ctrl.dmWe ? storeBe : 4'b0000;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIssue;
        end else begin
            case (state)
                stIssue: if (fetchGnt && memAccess) state <= stMem;
                stMem:   if (dataGnt) state <= stIssue;
                default: state <= stIssue;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIssue && fetchGnt) begin
            instrHold <= rdata;
        end
    end

    // held word must be a load or store whenever the data port is active
    dataOnlyInMem: assert property (@(posedge clk) disable iff (!arstN)
        dataReq.req |-> state == stMem && memAccess);

endmodule

// File: source/nextPc.sv
`timescale 1ns/1ns

module nextPc (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          advance,
    input  mipsPkg::npcOp_e               op,
    input  logic [15:0]                   imm16,
    input  logic [25:0]                   jIndex,
    input  logic [mipsPkg::DataWidth-1:0] regTarget,
    input  logic [mipsPkg::DataWidth-1:0] cmpA,
    input  logic [mipsPkg::DataWidth-1:0] cmpB,
    output logic [mipsPkg::DataWidth-1:0] pc,
    output logic [mipsPkg::DataWidth-1:0] pcPlus4
);
    import mipsPkg::*;

    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jumpTarget;
    logic [DataWidth-1:0] npc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jIndex, 2'b00};

    always_comb begin
        case (op)
            npcBeq:  npc = (cmpA == cmpB) ? branchTarget : pcPlus4;
            npcBgtz: npc = ($signed(cmpA) > 0) ? branchTarget : pcPlus4;
            npcJump: npc = jumpTarget;
            npcReg:  npc = regTarget;
            default: npc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (advance) begin
            pc <= npc;
        end
    end

endmodule

// File: source/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [mipsPkg::DataWidth-1:0] a,
    input  logic [mipsPkg::DataWidth-1:0] b,
    input  mipsPkg::aluOp_e               op,
    output logic [mipsPkg::DataWidth-1:0] result
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluOr:    result = a | b;
            aluLui:   result = b << 16;
            aluPassA: result = a;
            aluSll:   result = b << a[4:0]; // a carries shamt
            aluSlt:   result = {{(DataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            default:  result = '0;
        endcase
    end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [mipsPkg::RegAddrWidth-1:0] raddrA,
    input  logic [mipsPkg::RegAddrWidth-1:0] raddrB,
    input  logic [mipsPkg::RegAddrWidth-1:0] waddr,
    input  logic                             we,
    input  logic [mipsPkg::DataWidth-1:0]    wdata,
    output logic [mipsPkg::DataWidth-1:0]    rdataA,
    output logic [mipsPkg::DataWidth-1:0]    rdataB
);
    import mipsPkg::*;

    logic [DataWidth-1:0] regs [2**RegAddrWidth];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

    // write enable comes out of the core FSM and must never float once running
    weKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(we));

endmodule

// File: source/controller.sv
`timescale 1ns/1ns

module controller (
    input  logic [mipsPkg::DataWidth-1:0] instr,
    output mipsPkg::ctrl_t                ctrl
);
    import mipsPkg::*;

    opcode_e op;
    funct_e  fn;

    assign op = opcode_e'(instr[31:26]);
    assign fn = funct_e'(instr[5:0]);

    always_comb begin
        ctrl = CtrlIdle;
        if (instr != '0) begin // all-zero word is nop
            case (op)
                opRType: begin
                    case (fn)
                        fnAddu: begin
                            ctrl.wrSel = wrRd;
                            ctrl.rfWe  = 1'b1;
                            ctrl.aluOp = aluAdd;
                        end
                        fnSubu: begin
                            ctrl.wrSel = wrRd;
                            ctrl.rfWe  = 1'b1;
                            ctrl.aluOp = aluSub;
                        end
                        fnSll: begin
                            ctrl.wrSel = wrRd;
                            ctrl.rfWe  = 1'b1;
                            ctrl.aSel  = 1'b1; // shift amount from shamt
                            ctrl.aluOp = aluSll;
                        end
                        fnSlt: begin
                            ctrl.wrSel = wrRd;
                            ctrl.rfWe  = 1'b1;
                            ctrl.aluOp = aluSlt;
                        end
                        fnJr: begin
                            ctrl.npcOp = npcReg;
                            ctrl.aluOp = aluPassA;
                        end
                        default: ctrl = CtrlIdle;
                    endcase
                end
                opOri: begin
                    ctrl.rfWe  = 1'b1;
                    ctrl.bSel  = 1'b1;
                    ctrl.aluOp = aluOr;
                end
                opLui: begin
                    ctrl.rfWe  = 1'b1;
                    ctrl.bSel  = 1'b1;
                    ctrl.aluOp = aluLui;
                end
                opLw, opLb: begin
                    ctrl.wdSel  = wdMem;
                    ctrl.rfWe   = 1'b1;
                    ctrl.extOp  = extSign;
                    ctrl.bSel   = 1'b1;
                    ctrl.dmType = (op == opLb) ? memByte : memWord;
                end
                opSw, opSh: begin
                    ctrl.extOp  = extSign;
                    ctrl.bSel   = 1'b1;
                    ctrl.dmWe   = 1'b1;
                    ctrl.dmType = (op == opSh) ? memHalf : memWord;
                end
                opBeq: begin
                    ctrl.npcOp = npcBeq;
                    ctrl.extOp = extSign;
                end
                opBgtz: begin
                    ctrl.npcOp = npcBgtz;
                    ctrl.extOp = extSign;
                end
                opJ: ctrl.npcOp = npcJump;
                opJal: begin
                    ctrl.npcOp = npcJump;
                    ctrl.wrSel = wrRa;
                    ctrl.wdSel = wdPcLink;
                    ctrl.rfWe  = 1'b1;
                end
                default: ctrl = CtrlIdle;
            endcase
        end
    end

    // a load/store never writes both register file and memory in one instruction
    noDualWrite: assert final (!(ctrl.rfWe && ctrl.dmWe));

endmodule

// File: source/mipsPkg.sv
package mipsPkg;

    localparam int DataWidth    = 32;
    localparam int MemAddrWidth = 10; // 1024 words
    localparam int RegAddrWidth = 5;

    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opJ     = 6'b000010,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opBgtz  = 6'b000111,
        opOri   = 6'b001101,
        opLui   = 6'b001111,
        opLb    = 6'b100000,
        opLw    = 6'b100011,
        opSh    = 6'b101001,
        opSw    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnSlt  = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluOr, aluLui, aluPassA, aluSll, aluSlt
    } aluOp_e;

    typedef enum logic [2:0] {
        npcSeq, npcBeq, npcJump, npcReg, npcBgtz
    } npcOp_e;

    typedef enum logic [1:0] {wrRt, wrRd, wrRa} wrSel_e;
    typedef enum logic [1:0] {wdAlu, wdMem, wdPcLink} wdSel_e;
    typedef enum logic [1:0] {extZero, extSign} extOp_e;
    typedef enum logic [1:0] {memWord, memHalf, memByte} memType_e;

    typedef enum logic {stIssue, stMem} coreState_e;

    typedef struct packed {
        npcOp_e   npcOp;
        wrSel_e   wrSel;
        wdSel_e   wdSel;
        logic     rfWe;
        extOp_e   extOp;
        logic     aSel;   // 0 rs, 1 shamt
        logic     bSel;   // 0 rt, 1 immediate
        aluOp_e   aluOp;
        logic     dmWe;
        memType_e dmType;
    } ctrl_t;

    typedef struct packed {
        logic                    req;
        logic                    we;
        logic [MemAddrWidth-1:0] addr;
        logic [DataWidth-1:0]    wdata;
        logic [3:0]              be;
    } memReq_t;

    localparam ctrl_t CtrlIdle = '{
        npcOp:  npcSeq,
        wrSel:  wrRt,
        wdSel:  wdAlu,
        rfWe:   1'b0,
        extOp:  extZero,
        aSel:   1'b0,
        bSel:   1'b0,
        aluOp:  aluAdd,
        dmWe:   1'b0,
        dmType: memWord
    };

endpackage
